/* hdl/dcache_pkg.sv */
package dcache_pkg;

    // ------------------------------
    // Cache geometry
    // ------------------------------
    localparam int ADDR_W         = 16;
    localparam int WORD_W         = 32;
    localparam int WORDS_PER_LINE = 4;
    localparam int LINE_W         = 128;
    localparam int NUM_LINES      = 16;
    // Byte within a line
    localparam int OFFSET_W       = 4;
    localparam int INDEX_W        = 4;
    localparam int TAG_W          = 8;

    typedef logic [ADDR_W-1:0]                 addr_t;
    typedef logic [WORD_W-1:0]                 word_t;
    typedef logic [WORD_W/8-1:0]               be_t;
    typedef logic [LINE_W-1:0]                 line_t;
    typedef logic [LINE_W/8-1:0]               line_be_t;
    typedef logic [INDEX_W-1:0]                index_t;
    typedef logic [TAG_W-1:0]                  tag_t;
    typedef logic [$clog2(WORDS_PER_LINE)-1:0] word_off_t;

    // ------------------------------
    // Port and internal bundles
    // ------------------------------
    typedef struct packed {
        logic  valid;
        logic  we;
        addr_t addr;
        word_t wdata;
        be_t   be;
    } core_req_t;

    typedef struct packed {
        logic  gnt;
        logic  rvalid;
        word_t rdata;
    } core_resp_t;

    typedef struct packed {
        logic     en;
        logic     we;
        index_t   index;
        tag_t     tag;
        logic     valid;
        logic     dirty;
        line_t    wdata;
        line_be_t wmask;
    } array_req_t;

    typedef struct packed {
        tag_t  tag;
        logic  valid;
        logic  dirty;
        line_t data;
    } array_rdata_t;

    // Both addresses line-aligned
    typedef struct packed {
        logic  valid;
        logic  writeback;
        addr_t victim_addr;
        line_t victim_line;
        addr_t refill_addr;
    } miss_req_t;

    typedef struct packed {
        logic  valid;
        logic  we;
        addr_t addr;
        line_t wdata;
    } mem_req_t;

    // ------------------------------
    // State machines
    // ------------------------------
    typedef enum logic [2:0] {
        CTRL_IDLE,
        CTRL_LOOKUP,
        CTRL_COMPARE,
        CTRL_WAIT_REFILL,
        CTRL_REPLAY
    } ctrl_state_e;

    typedef enum logic [1:0] {
        MISS_IDLE,
        MISS_WRITEBACK,
        MISS_REFILL,
        MISS_DONE
    } miss_state_e;

endpackage

/* hdl/cache_ctrl.sv */
`timescale 1ns/10ps

module cache_ctrl (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  dcache_pkg::core_req_t    core_req_i,
    output dcache_pkg::core_resp_t   core_resp_o,
    output dcache_pkg::array_req_t   array_req_o,
    input  dcache_pkg::array_rdata_t array_rdata_i,
    output dcache_pkg::miss_req_t    miss_req_o,
    input  logic                     refill_valid_i,
    input  dcache_pkg::line_t        refill_line_i
);

    import dcache_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    core_req_t   req_q;
    line_t       line_q;

    index_t      req_index;
    tag_t        req_tag;
    word_off_t   req_woff;
    logic        hit;
    line_t       refill_merged;

    // Store bytes replace the addressed word in a line
    function automatic line_t merge_word(line_t base, word_t data, be_t be, word_off_t woff);
        line_t res;
        res = base;
        for (int b = 0; b < WORD_W/8; b++) begin
            if (be[b]) begin
                res[woff*WORD_W + b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return res;
    endfunction

    function automatic line_be_t store_mask(be_t be, word_off_t woff);
        line_be_t m;
        m = '0;
        m[woff*(WORD_W/8) +: WORD_W/8] = be;
        return m;
    endfunction

    function automatic word_t pick_word(line_t line, word_off_t woff);
        return line[woff*WORD_W +: WORD_W];
    endfunction

    // ------------------------------
    // Address split and tag compare
    // ------------------------------
    assign req_index = req_q.addr[OFFSET_W +: INDEX_W];
    assign req_tag   = req_q.addr[OFFSET_W+INDEX_W +: TAG_W];
    assign req_woff  = req_q.addr[OFFSET_W-1 -: $bits(word_off_t)];

    assign hit = array_rdata_i.valid && (array_rdata_i.tag == req_tag);

    assign refill_merged = req_q.we ? merge_word(refill_line_i, req_q.wdata, req_q.be, req_woff)
                                    : refill_line_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            CTRL_IDLE:        if (core_req_i.valid) state_d = CTRL_LOOKUP;
            CTRL_LOOKUP:      state_d = CTRL_COMPARE;
            CTRL_COMPARE:     state_d = hit ? CTRL_IDLE : CTRL_WAIT_REFILL;
            CTRL_WAIT_REFILL: if (refill_valid_i) state_d = CTRL_REPLAY;
            CTRL_REPLAY:      state_d = CTRL_IDLE;
            default:          state_d = CTRL_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= CTRL_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == CTRL_IDLE && core_req_i.valid) begin
            req_q <= core_req_i;
        end
        // Line as written on refill, kept for the replay word
        if (state_q == CTRL_WAIT_REFILL && refill_valid_i) begin
            line_q <= refill_merged;
        end
    end

    // ------------------------------
    // Array access
    // ------------------------------
    always_comb begin
        array_req_o       = '0;
        array_req_o.index = req_index;
        array_req_o.tag   = req_tag;
        case (state_q)
            CTRL_LOOKUP: begin
                array_req_o.en = 1'b1;
            end
            CTRL_COMPARE: begin
                if (hit && req_q.we) begin
                    array_req_o.en    = 1'b1;
                    array_req_o.we    = 1'b1;
                    array_req_o.valid = 1'b1;
                    array_req_o.dirty = 1'b1;
                    array_req_o.wdata = merge_word(array_rdata_i.data, req_q.wdata,
                                                   req_q.be, req_woff);
                    array_req_o.wmask = store_mask(req_q.be, req_woff);
                end
            end
            CTRL_WAIT_REFILL: begin
                if (refill_valid_i) begin
                    array_req_o.en    = 1'b1;
                    array_req_o.we    = 1'b1;
                    array_req_o.valid = 1'b1;
                    array_req_o.dirty = req_q.we;
                    array_req_o.wdata = refill_merged;
                    array_req_o.wmask = '1;
                end
            end
            default: ;
        endcase
    end

    // Victim fields come straight from the read register, idle while waiting
    always_comb begin
        miss_req_o.valid       = (state_q == CTRL_WAIT_REFILL);
        miss_req_o.writeback   = array_rdata_i.valid && array_rdata_i.dirty;
        miss_req_o.victim_addr = {array_rdata_i.tag, req_index, {OFFSET_W{1'b0}}};
        miss_req_o.victim_line = array_rdata_i.data;
        miss_req_o.refill_addr = {req_tag, req_index, {OFFSET_W{1'b0}}};
    end

    always_comb begin
        core_resp_o.gnt    = (state_q == CTRL_COMPARE && hit) || (state_q == CTRL_REPLAY);
        core_resp_o.rvalid = core_resp_o.gnt && !req_q.we;
        core_resp_o.rdata  = (state_q == CTRL_REPLAY) ? pick_word(line_q, req_woff)
                                                      : pick_word(array_rdata_i.data, req_woff);
    end

    // Every grant closes the access
    a_gnt_state: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        core_resp_o.gnt |=> state_q == CTRL_IDLE)
        else $error("access still open after gnt");

    // The array must not disturb the victim while the miss is open
    a_miss_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        miss_req_o.valid && !refill_valid_i |=> miss_req_o.valid && $stable(miss_req_o))
        else $error("miss request changed while waiting for refill");

endmodule

/* hdl/cache_array.sv */
`timescale 1ns/10ps

module cache_array (
    input  logic                     clk_i,
    input  logic                     rst_n_i,
    input  dcache_pkg::array_req_t   array_req_i,
    output dcache_pkg::array_rdata_t array_rdata_o
);

    import dcache_pkg::*;

    logic [NUM_LINES-1:0] valid_q;
    logic [NUM_LINES-1:0] dirty_q;
    tag_t                 tag_mem  [NUM_LINES];
    line_t                line_mem [NUM_LINES];

    logic  rd_en;
    logic  wr_en;
    line_t wr_line;

    // Read register
    logic  rd_valid_q;
    logic  rd_dirty_q;
    tag_t  rd_tag_q;
    line_t rd_data_q;

    assign rd_en = array_req_i.en && !array_req_i.we;
    assign wr_en = array_req_i.en && array_req_i.we;

    // Byte mask applied against the stored line
    always_comb begin
        wr_line = line_mem[array_req_i.index];
        for (int b = 0; b < LINE_W/8; b++) begin
            if (array_req_i.wmask[b]) begin
                wr_line[b*8 +: 8] = array_req_i.wdata[b*8 +: 8];
            end
        end
    end

    // ------------------------------
    // Flags
    // ------------------------------
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            valid_q    <= '0;
            dirty_q    <= '0;
            rd_valid_q <= 1'b0;
            rd_dirty_q <= 1'b0;
        end else begin
            if (wr_en) begin
                valid_q[array_req_i.index] <= array_req_i.valid;
                dirty_q[array_req_i.index] <= array_req_i.dirty;
            end
            if (rd_en) begin
                rd_valid_q <= valid_q[array_req_i.index];
                rd_dirty_q <= dirty_q[array_req_i.index];
            end
        end
    end

    // ------------------------------
    // Tag and line storage
    // ------------------------------
    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            tag_mem[array_req_i.index]  <= array_req_i.tag;
            line_mem[array_req_i.index] <= wr_line;
        end
        if (rd_en) begin
            rd_tag_q  <= tag_mem[array_req_i.index];
            rd_data_q <= line_mem[array_req_i.index];
        end
    end

    assign array_rdata_o = '{tag: rd_tag_q, valid: rd_valid_q, dirty: rd_dirty_q, data: rd_data_q};

    // An invalid line must never look dirty to the victim logic
    a_invalid_read: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rd_en && !valid_q[array_req_i.index] |=> !array_rdata_o.dirty)
        else $error("read of an invalid line returned dirty");

endmodule

/* hdl/miss_handler.sv */
`timescale 1ns/10ps

module miss_handler (
    input  logic                  clk_i,
    input  logic                  rst_n_i,
    input  dcache_pkg::miss_req_t miss_req_i,
    output logic                  refill_valid_o,
    output dcache_pkg::line_t     refill_line_o,
    output dcache_pkg::mem_req_t  mem_req_o,
    input  logic                  mem_gnt_i,
    input  logic                  mem_rvalid_i,
    input  dcache_pkg::line_t     mem_rdata_i
);

    import dcache_pkg::*;

    miss_state_e state_q;
    miss_state_e state_d;
    // Refill read granted, waiting for the line
    logic        rd_granted_q;
    logic        rd_granted_d;
    line_t       refill_q;
    logic        in_writeback;
    logic        refill_done;

    assign in_writeback = (state_q == MISS_WRITEBACK);
    assign refill_done  = (state_q == MISS_REFILL) && rd_granted_q && mem_rvalid_i;

    // ------------------------------
    // Sequence
    // ------------------------------
    always_comb begin
        state_d      = state_q;
        rd_granted_d = rd_granted_q;
        case (state_q)
            MISS_IDLE: begin
                if (miss_req_i.valid) begin
                    state_d = miss_req_i.writeback ? MISS_WRITEBACK : MISS_REFILL;
                end
            end
            MISS_WRITEBACK: begin
                // Write completes at its grant
                if (mem_gnt_i) begin
                    state_d = MISS_REFILL;
                end
            end
            MISS_REFILL: begin
                if (!rd_granted_q) begin
                    if (mem_gnt_i) begin
                        rd_granted_d = 1'b1;
                    end
                end else if (mem_rvalid_i) begin
                    rd_granted_d = 1'b0;
                    state_d      = MISS_DONE;
                end
            end
            MISS_DONE: begin
                state_d = MISS_IDLE;
            end
            default: begin
                state_d = MISS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= MISS_IDLE;
            rd_granted_q <= 1'b0;
        end else begin
            state_q      <= state_d;
            rd_granted_q <= rd_granted_d;
        end
    end

    always_ff @(posedge clk_i) begin
        if (refill_done) begin
            refill_q <= mem_rdata_i;
        end
    end

    // ------------------------------
    // Memory port
    // ------------------------------
    always_comb begin
        mem_req_o.valid = in_writeback || (state_q == MISS_REFILL && !rd_granted_q);
        mem_req_o.we    = in_writeback;
        mem_req_o.addr  = in_writeback ? miss_req_i.victim_addr : miss_req_i.refill_addr;
        mem_req_o.wdata = miss_req_i.victim_line;
    end

    // One-cycle pulse back to the controller
    assign refill_valid_o = (state_q == MISS_DONE);
    assign refill_line_o  = refill_q;

    a_mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mem_req_o.valid && !mem_gnt_i |=> mem_req_o.valid && $stable(mem_req_o))
        else $error("memory request changed before grant");

endmodule

/* hdl/dcache_top.sv */
`timescale 1ns/10ps

module dcache_top (
    input  logic                   clk_i,
    input  logic                   rst_n_i,
    input  dcache_pkg::core_req_t  core_req_i,
    output dcache_pkg::core_resp_t core_resp_o,
    output dcache_pkg::mem_req_t   mem_req_o,
    input  logic                   mem_gnt_i,
    input  logic                   mem_rvalid_i,
    input  dcache_pkg::line_t      mem_rdata_i
);

    import dcache_pkg::*;

    // ------------------------------
    // Internal links
    // ------------------------------
    array_req_t   array_req;
    array_rdata_t array_rdata;
    miss_req_t    miss_req;
    logic         refill_valid;
    line_t        refill_line;

    cache_ctrl i_cache_ctrl (
        .clk_i          ( clk_i        ),
        .rst_n_i        ( rst_n_i      ),
        .core_req_i     ( core_req_i   ),
        .core_resp_o    ( core_resp_o  ),
        .array_req_o    ( array_req    ),
        .array_rdata_i  ( array_rdata  ),
        .miss_req_o     ( miss_req     ),
        .refill_valid_i ( refill_valid ),
        .refill_line_i  ( refill_line  )
    );

    cache_array i_cache_array (
        .clk_i         ( clk_i       ),
        .rst_n_i       ( rst_n_i     ),
        .array_req_i   ( array_req   ),
        .array_rdata_o ( array_rdata )
    );

    miss_handler i_miss_handler (
        .clk_i          ( clk_i        ),
        .rst_n_i        ( rst_n_i      ),
        .miss_req_i     ( miss_req     ),
        .refill_valid_o ( refill_valid ),
        .refill_line_o  ( refill_line  ),
        .mem_req_o      ( mem_req_o    ),
        .mem_gnt_i      ( mem_gnt_i    ),
        .mem_rvalid_i   ( mem_rvalid_i ),
        .mem_rdata_i    ( mem_rdata_i  )
    );

endmodule

/* bench/clk_gen.sv */
`timescale 1ns/10ps

module clk_gen (
    output logic clk_o
);

    // 4 ns period
    localparam int HALF_PERIOD_NS = 2;

    initial begin
        clk_o = 1'b0;
        forever begin
            #HALF_PERIOD_NS clk_o = ~clk_o;
        end
    end

endmodule

/* bench/tb_dcache.sv */
`timescale 1ns/10ps

module tb_dcache;

    import dcache_pkg::*;

    localparam int    NUM_CASES      = 24;
    // op, addr, wdata, be, rdata, kind
    localparam int    FIELDS         = 6;
    localparam int    RESET_CYCLES   = 16;
    localparam int    MAX_CYCLES     = 200 * NUM_CASES;
    localparam int    DRIVE_DELAY_NS = 1;
    localparam int    MEM_SEED       = 95;
    localparam string CASES_FILE     = "bench/dcache_cases.txt";

    logic       clk;
    logic       rst_n;
    core_req_t  core_req;
    core_resp_t core_resp;
    mem_req_t   mem_req;
    logic       mem_gnt;
    logic       mem_rvalid;
    line_t      mem_rdata;

    logic [31:0] case_words [NUM_CASES*FIELDS];
    line_t       mem_lines  [addr_t];
    // Line contents as the core sees them after every granted store
    line_t       ref_lines  [addr_t];
    addr_t       active_line;
    int          mem_reads;
    int          mem_writes;
    int          stim_errors;
    int          mem_errors;
    int          mon_errors;

    clk_gen i_clk_gen (
        .clk_o ( clk )
    );

    dcache_top dcache_top_i (
        .clk_i        ( clk        ),
        .rst_n_i      ( rst_n      ),
        .core_req_i   ( core_req   ),
        .core_resp_o  ( core_resp  ),
        .mem_req_o    ( mem_req    ),
        .mem_gnt_i    ( mem_gnt    ),
        .mem_rvalid_i ( mem_rvalid ),
        .mem_rdata_i  ( mem_rdata  )
    );

    // ------------------------------
    // Reference contents
    // ------------------------------
    // Word w of line A holds A+4w on top and its complement below
    function automatic line_t rule_line(addr_t line_addr);
        line_t res;
        addr_t a;
        for (int w = 0; w < WORDS_PER_LINE; w++) begin
            a = line_addr + addr_t'(4 * w);
            res[w*WORD_W +: WORD_W] = {a, ~a};
        end
        return res;
    endfunction

    function automatic line_t apply_store(line_t base, addr_t addr, word_t data, be_t be);
        line_t res;
        int    first_bit;
        res       = base;
        first_bit = int'(addr[OFFSET_W-1:2]) * WORD_W;
        for (int b = 0; b < WORD_W/8; b++) begin
            if (be[b]) begin
                res[first_bit + 8*b +: 8] = data[8*b +: 8];
            end
        end
        return res;
    endfunction

    function automatic line_t expected_line(addr_t line_addr);
        if (ref_lines.exists(line_addr)) begin
            return ref_lines[line_addr];
        end
        return rule_line(line_addr);
    endfunction

    function automatic line_t stored_line(addr_t line_addr);
        if (mem_lines.exists(line_addr)) begin
            return mem_lines[line_addr];
        end
        return rule_line(line_addr);
    endfunction

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task automatic check_word(input string name, input word_t got, input word_t exp,
                              inout int errors);
        if (got !== exp) begin
            $display("** Error: %s = 0x%08h, expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_line(input string name, input line_t got, input line_t exp,
                              inout int errors);
        if (got !== exp) begin
            $display("** Error: %s = 0x%032h, expected 0x%032h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp,
                              inout int errors);
        if (got !== exp) begin
            $display("** Error: %s = 0x%04h, expected 0x%04h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp,
                               inout int errors);
        if (got != exp) begin
            $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    // ------------------------------
    // Memory model
    // ------------------------------
    task automatic serve_request();
        mem_req_t held;
        int       delay;
        held  = mem_req;
        delay = $urandom_range(5, 0);
        repeat (delay) begin
            @(posedge clk);
            #DRIVE_DELAY_NS;
            if (mem_req !== held) begin
                $display("Memory request changed or dropped before its grant");
                mem_errors++;
            end
        end
        mem_gnt = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY_NS;
        mem_gnt = 1'b0;
        if (held.we) begin
            mem_writes++;
            check_line("mem_req_o.wdata", held.wdata, expected_line(held.addr), mem_errors);
            mem_lines[held.addr] = held.wdata;
        end else begin
            mem_reads++;
            check_addr("mem_req_o.addr", held.addr, active_line, mem_errors);
            // Data 1 to 5 cycles after the grant
            delay = $urandom_range(5, 1);
            repeat (delay - 1) begin
                @(posedge clk);
                #DRIVE_DELAY_NS;
            end
            mem_rvalid = 1'b1;
            mem_rdata  = stored_line(held.addr);
            @(posedge clk);
            #DRIVE_DELAY_NS;
            mem_rvalid = 1'b0;
        end
    endtask

    initial begin : memory_model
        void'($urandom(MEM_SEED));
        mem_gnt    = 1'b0;
        mem_rvalid = 1'b0;
        mem_rdata  = '0;
        mem_reads  = 0;
        mem_writes = 0;
        mem_errors = 0;
        forever begin
            @(posedge clk);
            #DRIVE_DELAY_NS;
            if (rst_n && mem_req.valid) begin
                serve_request();
            end
        end
    end

    initial begin : request_monitor
        mon_errors = 0;
        forever begin
            @(negedge clk);
            if (rst_n && core_resp.gnt && !core_req.valid) begin
                $display("Cache granted a core request that was not held");
                mon_errors++;
            end
        end
    end

    initial begin : watchdog
        int cycle_count;
        cycle_count = 0;
        while (cycle_count < MAX_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    // ------------------------------
    // Core side
    // ------------------------------
    task automatic run_case(input int idx, output bit passed);
        core_req_t req;
        word_t     exp_rdata;
        int        kind;
        int        cycles;
        int        reads_before;
        int        writes_before;
        int        errors_before;
        logic      got_gnt;
        logic      got_rvalid;
        word_t     got_rdata;
        addr_t     line_addr;
        req.valid     = 1'b1;
        req.we        = case_words[idx*FIELDS][0];
        req.addr      = case_words[idx*FIELDS+1][ADDR_W-1:0];
        req.wdata     = case_words[idx*FIELDS+2];
        req.be        = case_words[idx*FIELDS+3][3:0];
        exp_rdata     = case_words[idx*FIELDS+4];
        kind          = int'(case_words[idx*FIELDS+5]);
        line_addr     = {req.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        active_line   = line_addr;
        reads_before  = mem_reads;
        writes_before = mem_writes;
        errors_before = stim_errors + mem_errors + mon_errors;
        core_req      = req;
        cycles        = 0;
        got_gnt       = 1'b0;
        while (!got_gnt) begin
            @(posedge clk);
            #DRIVE_DELAY_NS;
            cycles++;
            got_gnt = core_resp.gnt;
        end
        got_rvalid = core_resp.rvalid;
        got_rdata  = core_resp.rdata;
        // Request stays up through the grant cycle
        @(posedge clk);
        #DRIVE_DELAY_NS;
        core_req = '0;
        // One idle cycle so that a stray gnt shows up
        @(posedge clk);
        #DRIVE_DELAY_NS;
        if (req.we) begin
            if (got_rvalid) begin
                $display("Store to 0x%04h came back with rvalid", req.addr);
                stim_errors++;
            end
            ref_lines[line_addr] = apply_store(expected_line(line_addr), req.addr,
                                               req.wdata, req.be);
        end else begin
            if (!got_rvalid) begin
                $display("Load from 0x%04h was granted without rvalid", req.addr);
                stim_errors++;
            end
            check_word("core_resp_o.rdata", got_rdata, exp_rdata, stim_errors);
        end
        if (kind == 0) begin
            check_count("hit latency", cycles, 2, stim_errors);
        end
        check_count("memory reads", mem_reads - reads_before, (kind == 0) ? 0 : 1,
                    stim_errors);
        check_count("memory writes", mem_writes - writes_before, (kind == 2) ? 1 : 0,
                    stim_errors);
        passed = (stim_errors + mem_errors + mon_errors == errors_before);
        $display("case %0d: %s 0x%04h, %0d cycles, %s", idx, req.we ? "store" : "load",
                 req.addr, cycles, passed ? "ok" : "error");
    endtask

    initial begin : stimulus
        int failed_cases;
        bit passed;
        core_req     = '0;
        rst_n        = 1'b0;
        active_line  = '0;
        stim_errors  = 0;
        failed_cases = 0;
        $readmemh(CASES_FILE, case_words);
        repeat (RESET_CYCLES) begin
            @(posedge clk);
        end
        #DRIVE_DELAY_NS;
        rst_n = 1'b1;
        for (int i = 0; i < NUM_CASES; i++) begin
            run_case(i, passed);
            if (!passed) begin
                failed_cases++;
            end
        end
        $display("Summary: %0d cases, %0d passed, %0d failed, %0d errors", NUM_CASES,
                 NUM_CASES - failed_cases, failed_cases,
                 stim_errors + mem_errors + mon_errors);
        if (failed_cases == 0 && stim_errors + mem_errors + mon_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* bench/dcache_cases.txt */
// op addr wdata be rdata kind (hex)
// op 0 load, 1 store; kind 0 hit, 1 miss, 2 miss with write-back; rdata checked on loads
0 0104 00000000 0 0104FEFB 1
0 0108 00000000 0 0108FEF7 0
0 0104 00000000 0 0104FEFB 0
1 0104 AABBCCDD 3 00000000 0
0 0104 00000000 0 0104CCDD 0
1 010C 11223344 C 00000000 0
0 010C 00000000 0 1122FEF3 0
0 0204 00000000 0 0204FDFB 2
0 0104 00000000 0 0104CCDD 1
0 010C 00000000 0 1122FEF3 0
1 0310 DEADBEEF F 00000000 1
0 0310 00000000 0 DEADBEEF 0
0 0314 00000000 0 0314FCEB 0
1 0428 00005A00 2 00000000 1
0 0428 00000000 0 04285AD7 0
0 0520 00000000 0 0520FADF 2
0 0428 00000000 0 04285AD7 1
1 0310 00000077 1 00000000 0
0 FF3C 00000000 0 FF3C00C3 1
0 1318 00000000 0 1318ECE7 2
0 0310 00000000 0 DEADBE77 1
0 0314 00000000 0 0314FCEB 0
1 FF30 01020304 F 00000000 0
0 FF30 00000000 0 01020304 0

/* all.f */
hdl/dcache_pkg.sv
hdl/cache_ctrl.sv
hdl/cache_array.sv
hdl/miss_handler.sv
hdl/dcache_top.sv
bench/clk_gen.sv
bench/tb_dcache.sv

/* run.sh */
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -j 0 --top-module tb_dcache -f all.f -o sim_dcache \
    || { echo "Build failed"; exit 1; }
./obj_dir/sim_dcache | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
